//--- stream_pkg.sv
package stream_pkg;

    // Width of every word on every stream
    localparam int data_w = 16;

    // Pipe stage occupancy
    //   st_idle       no word held
    //   st_valid      one word at the output, side buffer empty
    //   st_valid_buf  one word at the output, one more in the side buffer
    typedef enum logic [1:0] {
        st_idle      = 2'b00,
        st_valid     = 2'b01,
        st_valid_buf = 2'b10
    } pipe_state_t;

endpackage

//--- stream_if.sv
`timescale 1ns/100ps

// Valid/ready stream, one word per handshake
interface stream_if;

    logic                          valid;
    logic                          ready;
    logic [stream_pkg::data_w-1:0] data;

    // Producer side
    modport source (
        output valid,
        output data,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface

//--- stream_pipe_stage.sv
`timescale 1ns/100ps

// Elastic stage with registered ready and valid.
// A side buffer catches the one word that can slip in while
// the output is stalled, since upstream only sees ready a cycle late.
module stream_pipe_stage (
    input  logic      clock,
    input  logic      rst_n,
    output logic      empty,
    stream_if.sink    up,
    stream_if.source  down
);

    stream_pkg::pipe_state_t state;
    stream_pkg::pipe_state_t nstate;

    logic [stream_pkg::data_w-1:0] buf_data;
    logic                          buf_valid;

    logic up_take;
    logic down_take;
    logic load_from_up;
    logic load_from_buf;
    logic load_buf;

    assign up_take   = up.valid && up.ready;
    assign down_take = down.valid && down.ready;

    // Next state from the two handshakes
    always_comb begin
        nstate = state;
        case (state)
            stream_pkg::st_idle: begin
                if (up_take) begin
                    nstate = stream_pkg::st_valid;
                end
            end
            stream_pkg::st_valid: begin
                case ({down_take, up_take})
                    2'b00:   nstate = stream_pkg::st_valid;
                    2'b10:   nstate = stream_pkg::st_idle;
                    2'b01:   nstate = stream_pkg::st_valid_buf;
                    2'b11:   nstate = stream_pkg::st_valid;
                    default: nstate = stream_pkg::st_idle;
                endcase
            end
            stream_pkg::st_valid_buf: begin
                // Upstream is held off here, only the output can move
                if (down_take) begin
                    nstate = stream_pkg::st_valid;
                end
            end
            default: begin
                nstate = stream_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= stream_pkg::st_idle;
        end else begin
            state <= nstate;
        end
    end

    // Ready drops once the side buffer fills, low through reset
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            up.ready <= 1'b0;
        end else begin
            up.ready <= (nstate != stream_pkg::st_valid_buf);
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= (nstate != stream_pkg::st_idle);
        end
    end

    // Where the next output word comes from
    assign load_from_buf = (state == stream_pkg::st_valid_buf) && down_take;
    assign load_from_up  = up_take &&
                           ((state == stream_pkg::st_idle) ||
                            ((state == stream_pkg::st_valid) && down_take));
    // Output stalled while a word arrives
    assign load_buf      = up_take && (state == stream_pkg::st_valid) && !down_take;

    always_ff @(posedge clock) begin
        if (load_from_buf) begin
            down.data <= buf_data;
        end else if (load_from_up) begin
            down.data <= up.data;
        end
    end

    always_ff @(posedge clock) begin
        if (load_buf) begin
            buf_data <= up.data;
        end
    end

    assign buf_valid = (state == stream_pkg::st_valid_buf);

    // Nothing at the output and nothing parked
    assign empty = !(buf_valid || down.valid);

endmodule

//--- prefix_sum_stage.sv
`timescale 1ns/100ps

// Replaces each accepted word with the running sum of all accepted
// words, modulo 2^16. One output register, so latency is one cycle.
module prefix_sum_stage (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      clear_sum,
    output logic      busy,
    stream_if.sink    up,
    stream_if.source  down
);

    logic [stream_pkg::data_w-1:0] acc;
    logic [stream_pkg::data_w-1:0] sum_base;
    logic [stream_pkg::data_w-1:0] sum_next;

    logic up_take;

    // Accept when the output is free or leaves this cycle
    assign up.ready = !down.valid || down.ready;
    assign up_take  = up.valid && up.ready;

    // A clear in the same cycle makes this word start a new sum
    assign sum_base = clear_sum ? '0 : acc;

    // Carry out of the top bit is dropped on purpose
    assign sum_next = sum_base + up.data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (up_take) begin
            acc <= sum_next;
        end else if (clear_sum) begin
            acc <= '0;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            down.valid <= 1'b0;
        end else if (up_take) begin
            down.valid <= 1'b1;
        end else if (down.ready) begin
            down.valid <= 1'b0;
        end
    end

    // Payload only
    always_ff @(posedge clock) begin
        if (up_take) begin
            down.data <= sum_next;
        end
    end

    assign busy = down.valid;

endmodule

//--- stream_sum_top.sv
`timescale 1ns/100ps

// Input pipe stage, running-sum stage, output pipe stage
module stream_sum_top (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          clear_sum,

    input  logic                          in_valid,
    input  logic [stream_pkg::data_w-1:0] in_data,
    output logic                          in_ready,

    output logic                          out_valid,
    output logic [stream_pkg::data_w-1:0] out_data,
    input  logic                          out_ready,

    output logic                          idle
);

    stream_if s_in  ();
    stream_if s_mid ();
    stream_if s_sum ();
    stream_if s_out ();

    logic in_empty;
    logic out_empty;
    logic sum_busy;

    // Outside input port onto the first stream
    assign s_in.valid = in_valid;
    assign s_in.data  = in_data;
    assign in_ready   = s_in.ready;

    stream_pipe_stage u_in_stage (
        .clock (clock),
        .rst_n (rst_n),
        .empty (in_empty),
        .up    (s_in),
        .down  (s_mid)
    );

    prefix_sum_stage u_sum (
        .clock     (clock),
        .rst_n     (rst_n),
        .clear_sum (clear_sum),
        .busy      (sum_busy),
        .up        (s_mid),
        .down      (s_sum)
    );

    stream_pipe_stage u_out_stage (
        .clock (clock),
        .rst_n (rst_n),
        .empty (out_empty),
        .up    (s_sum),
        .down  (s_out)
    );

    // Last stream out to the output port
    assign out_valid   = s_out.valid;
    assign out_data    = s_out.data;
    assign s_out.ready = out_ready;

    // No word held in any stage
    assign idle = in_empty && !sum_busy && out_empty;

endmodule

//--- stream_sum_assertions.sv
`timescale 1ns/100ps

// Protocol checks on the top-level ports and the two pipe stage states
module stream_sum_assertions (
    input logic                          clock,
    input logic                          rst_n,
    input logic                          in_valid,
    input logic                          in_ready,
    input logic                          out_valid,
    input logic [stream_pkg::data_w-1:0] out_data,
    input logic                          out_ready,
    input logic                          idle,
    input stream_pkg::pipe_state_t       in_state,
    input stream_pkg::pipe_state_t       out_state
);

    // High from the second clock edge of a reset onward
    logic reset_held;

    always_ff @(posedge clock) begin
        reset_held <= !rst_n;
    end

    // A stalled output word stays put until it is taken
    out_word_holds: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_data changed or out_valid dropped while stalled");

    reset_outputs_low: assert property (@(posedge clock)
        reset_held && !rst_n |-> !out_valid && !in_ready)
        else $error("out_valid or in_ready high during reset");

    // An empty path stays empty until a word is taken in
    idle_stays_idle: assert property (@(posedge clock) disable iff (!rst_n)
        idle && !(in_valid && in_ready) |=> idle)
        else $error("idle dropped although no word entered the path");

    // Output side buffer only holds a word behind a stalled output
    out_buffer_after_stall: assert property (@(posedge clock) disable iff (!rst_n)
        out_state == stream_pkg::st_valid_buf |-> $past(out_valid && !out_ready))
        else $error("output side buffer full without a stalled output word");

    // Input side buffer fills only on a real input handshake
    in_buffer_after_take: assert property (@(posedge clock) disable iff (!rst_n)
        in_state == stream_pkg::st_valid_buf &&
        $past(in_state) != stream_pkg::st_valid_buf |-> $past(in_valid && in_ready))
        else $error("input side buffer filled without an input handshake");

endmodule

bind stream_sum_top stream_sum_assertions u_protocol_checks (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .idle      (idle),
    .in_state  (u_in_stage.state),
    .out_state (u_out_stage.state)
);

//--- stream_sum_tb.sv
`timescale 1ns/100ps

module stream_sum_tb;

    logic                          clock = 1'b0;
    logic                          rst_n;
    logic                          clear_sum;
    logic                          in_valid;
    logic [stream_pkg::data_w-1:0] in_data;
    logic                          in_ready;
    logic                          out_valid;
    logic [stream_pkg::data_w-1:0] out_data;
    logic                          out_ready;
    logic                          idle;

    // Random source and output stall pattern
    logic [31:0] lcg_state = 32'h5376_5818;
    bit          stall_mode;
    int          stall_left;

    // Word counts per phase
    int sum_words     = 40;
    int latency_words = 3;
    int bp_words      = 200;
    int clear_rounds  = 12;
    int cycle_limit;

    // Reference model, owned by the monitor
    logic [stream_pkg::data_w-1:0] model_acc = '0;
    logic [stream_pkg::data_w-1:0] expected_sums[$];
    bit                            clear_this_word;

    // Handshakes seen at the falling edge complete on the next rising edge
    bit in_hs = 1'b0;
    bit out_hs = 1'b0;
    int neg_count = 0;

    bit latency_probe;
    bit probe_open = 1'b0;
    int probe_start = 0;

    stream_sum_top i_stream_sum_top (
        .clock     (clock),
        .rst_n     (rst_n),
        .clear_sum (clear_sum),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .idle      (idle)
    );

    initial begin
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Next drive point, a little after the rising edge
    task automatic advance();
        logic [31:0] r;
        @(posedge clock);
        #2;
        if (!stall_mode) begin
            out_ready = 1'b1;
        end else if (stall_left > 0) begin
            out_ready = 1'b0;
            stall_left = stall_left - 1;
        end else begin
            r = next_rand();
            if (r[17:16] == 2'd0) begin
                // Stall of one to eight cycles
                out_ready = 1'b0;
                stall_left = int'(r[20:18]);
            end else begin
                out_ready = 1'b1;
            end
        end
    endtask

    task automatic send_word(input logic [stream_pkg::data_w-1:0] word);
        in_data = word;
        in_valid = 1'b1;
        do begin
            advance();
        end while (!in_hs);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (!idle) begin
            advance();
        end
        assert (expected_sums.size() == 0)
            else stop_run("Path went idle while expected sums were still queued");
    endtask

    always @(negedge clock) begin
        in_hs = in_valid && in_ready;
        out_hs = out_valid && out_ready;
        neg_count = neg_count + 1;
        if (neg_count > cycle_limit) begin
            stop_run($sformatf("Timeout: run went past %0d cycles", cycle_limit));
        end
        if (clear_sum && !clear_this_word) begin
            model_acc = '0;
        end
        if (in_hs) begin
            // Running sum, restarted by a clear that meets this word
            if (clear_this_word) begin
                model_acc = in_data;
            end else begin
                model_acc = model_acc + in_data;
            end
            expected_sums.push_back(model_acc);
            if (latency_probe) begin
                probe_start = neg_count;
                probe_open = 1'b1;
            end
        end
        if (probe_open && out_valid) begin
            assert (neg_count - probe_start == 3)
                else stop_run($sformatf("FAIL %0t: latency %0d cycles, expected 3",
                                        $time, neg_count - probe_start));
            probe_open = 1'b0;
        end
        if (out_hs) begin
            assert (expected_sums.size() > 0)
                else stop_run("Output word taken while no word was expected");
            assert (out_data == expected_sums[0])
                else stop_run($sformatf("FAIL %0t: out_data %04h, expected %04h",
                                        $time, out_data, expected_sums[0]));
            void'(expected_sums.pop_front());
        end
    end

    initial begin
        logic [31:0] r;
        rst_n = 1'b0;
        clear_sum = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b0;
        stall_mode = 1'b0;
        stall_left = 0;
        clear_this_word = 1'b0;
        latency_probe = 1'b0;
        // Gap of up to 3, stall of up to 8, pipe depth, plus reset and drains
        cycle_limit = (sum_words + latency_words + bp_words + clear_rounds * 4) *
                      (3 + 8 + 4) + 500;

        repeat (8) @(posedge clock);
        #2;
        rst_n = 1'b1;
        assert (!out_valid && idle && !in_ready)
            else stop_run("Wrong out_valid, idle or in_ready right after reset");
        advance();
        assert (in_ready)
            else stop_run("in_ready did not rise one cycle after reset release");

        // Running sum, no back-pressure
        for (int i = 0; i < sum_words; i++) begin
            r = next_rand();
            send_word(r[31:16]);
        end
        drain();

        // Single words through an empty path
        latency_probe = 1'b1;
        for (int i = 0; i < latency_words; i++) begin
            r = next_rand();
            send_word(r[31:16]);
            drain();
        end
        latency_probe = 1'b0;

        // Random input gaps and output stalls
        stall_mode = 1'b1;
        for (int i = 0; i < bp_words; i++) begin
            r = next_rand();
            repeat (int'(r[29:28])) advance();
            r = next_rand();
            send_word(r[31:16]);
        end
        drain();
        stall_mode = 1'b0;
        stall_left = 0;

        // Clear alone, or in the cycle the sum stage takes a word
        for (int c = 0; c < clear_rounds; c++) begin
            r = next_rand();
            if (r[31]) begin
                clear_sum = 1'b1;
                advance();
                clear_sum = 1'b0;
            end else begin
                clear_this_word = 1'b1;
                r = next_rand();
                send_word(r[31:16]);
                clear_sum = 1'b1;
                advance();
                clear_sum = 1'b0;
                clear_this_word = 1'b0;
            end
            for (int i = 0; i < 3; i++) begin
                r = next_rand();
                send_word(r[31:16]);
            end
            drain();
        end

        if (expected_sums.size() == 0 && idle) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_run("Words were left in flight at the end of the run");
        end
    end

endmodule

//--- flist.f
stream_pkg.sv
stream_if.sv
stream_pipe_stage.sv
prefix_sum_stage.sv
stream_sum_top.sv
stream_sum_assertions.sv
stream_sum_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the stream sum testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module stream_sum_tb \
    -f flist.f \
    -o stream_sum_sim

./obj_dir/stream_sum_sim
